/* verilog/core_pkg.sv */
package core_pkg;

    localparam int word_width     = 32;
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;

    // 3R major opcodes, inst[31:15]
    localparam logic [16:0] op3r_add  = 17'h00020;
    localparam logic [16:0] op3r_sub  = 17'h00022;
    localparam logic [16:0] op3r_slt  = 17'h00024;
    localparam logic [16:0] op3r_sltu = 17'h00025;
    localparam logic [16:0] op3r_nor  = 17'h00028;
    localparam logic [16:0] op3r_and  = 17'h00029;
    localparam logic [16:0] op3r_or   = 17'h0002a;
    localparam logic [16:0] op3r_xor  = 17'h0002b;

    // 2RI12 major opcodes, inst[31:22]
    localparam logic [9:0] op2ri12_slti  = 10'h008;
    localparam logic [9:0] op2ri12_sltui = 10'h009;
    localparam logic [9:0] op2ri12_addi  = 10'h00a;
    localparam logic [9:0] op2ri12_andi  = 10'h00d;
    localparam logic [9:0] op2ri12_ori   = 10'h00e;
    localparam logic [9:0] op2ri12_xori  = 10'h00f;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_sltu,
        alu_and,
        alu_or,
        alu_nor,
        alu_xor
    } alu_op_e;

    typedef struct packed {
        logic [16:0]               opcode;
        logic [reg_addr_width-1:0] rk;
        logic [reg_addr_width-1:0] rj;
        logic [reg_addr_width-1:0] rd;
    } inst_3r_t;

    typedef struct packed {
        logic [9:0]                opcode;
        logic [11:0]               imm12;
        logic [reg_addr_width-1:0] rj;
        logic [reg_addr_width-1:0] rd;
    } inst_2ri12_t;

    // same word, two decodings
    typedef union packed {
        inst_3r_t    fmt_3r;
        inst_2ri12_t fmt_2ri12;
    } inst_word_u;

    typedef struct packed {
        logic                      valid;
        alu_op_e                   alu_op;
        logic [reg_addr_width-1:0] rj;
        logic [reg_addr_width-1:0] rk;
        logic                      use_imm;
        logic [word_width-1:0]     imm;
        logic [reg_addr_width-1:0] rd;
        logic                      rf_we;
    } decoded_t;

    typedef struct packed {
        logic                      valid;
        logic                      rf_we;
        logic [reg_addr_width-1:0] rd;
        logic [word_width-1:0]     data;
    } exec_result_t;

    // external retirement port
    typedef struct packed {
        logic                      valid;
        logic                      rf_we;
        logic [reg_addr_width-1:0] rd;
        logic [word_width-1:0]     data;
    } wb_trace_t;

endpackage

/* verilog/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       inst_valid,
    input  inst_word_u inst,
    output decoded_t   dec
);

    decoded_t              dec_next;
    logic                  legal;
    logic [word_width-1:0] imm_sext;
    logic [word_width-1:0] imm_zext;

    assign imm_sext = {{(word_width-12){inst.fmt_2ri12.imm12[11]}}, inst.fmt_2ri12.imm12};
    assign imm_zext = {{(word_width-12){1'b0}}, inst.fmt_2ri12.imm12};

    always_comb begin
        dec_next         = '0;
        legal            = 1'b1;
        dec_next.rj      = inst.fmt_3r.rj;
        dec_next.rk      = inst.fmt_3r.rk;
        dec_next.rd      = inst.fmt_3r.rd;
        dec_next.alu_op  = alu_add;
        dec_next.use_imm = 1'b0;

        case (inst.fmt_3r.opcode)
            op3r_add:  dec_next.alu_op = alu_add;
            op3r_sub:  dec_next.alu_op = alu_sub;
            op3r_slt:  dec_next.alu_op = alu_slt;
            op3r_sltu: dec_next.alu_op = alu_sltu;
            op3r_nor:  dec_next.alu_op = alu_nor;
            op3r_and:  dec_next.alu_op = alu_and;
            op3r_or:   dec_next.alu_op = alu_or;
            op3r_xor:  dec_next.alu_op = alu_xor;
            default: begin
                // not 3R, try the immediate format
                dec_next.use_imm = 1'b1;
                dec_next.rk      = '0;
                case (inst.fmt_2ri12.opcode)
                    op2ri12_addi: begin
                        dec_next.alu_op = alu_add;
                        dec_next.imm    = imm_sext;
                    end
                    op2ri12_slti: begin
                        dec_next.alu_op = alu_slt;
                        dec_next.imm    = imm_sext;
                    end
                    op2ri12_sltui: begin
                        // sign-extended, compared unsigned
                        dec_next.alu_op = alu_sltu;
                        dec_next.imm    = imm_sext;
                    end
                    op2ri12_andi: begin
                        dec_next.alu_op = alu_and;
                        dec_next.imm    = imm_zext;
                    end
                    op2ri12_ori: begin
                        dec_next.alu_op = alu_or;
                        dec_next.imm    = imm_zext;
                    end
                    op2ri12_xori: begin
                        dec_next.alu_op = alu_xor;
                        dec_next.imm    = imm_zext;
                    end
                    default: legal = 1'b0;
                endcase
            end
        endcase

        dec_next.valid = inst_valid && legal;
        // r0 never written
        dec_next.rf_we = legal && (dec_next.rd != '0);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec <= '0;
        end else begin
            dec <= dec_next;
        end
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage import core_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  decoded_t                  dec,
    output logic [reg_addr_width-1:0] rf_raddr1,
    output logic [reg_addr_width-1:0] rf_raddr2,
    input  logic [word_width-1:0]     rf_rdata1,
    input  logic [word_width-1:0]     rf_rdata2,
    output exec_result_t              exe
);

    logic                  bypass1;
    logic                  bypass2;
    logic [word_width-1:0] src1;
    logic [word_width-1:0] src2_reg;
    logic [word_width-1:0] src2;
    logic [word_width-1:0] alu_result;
    exec_result_t          exe_next;

    assign rf_raddr1 = dec.rj;
    assign rf_raddr2 = dec.rk;

    // previous instruction still sits in exe, not yet in the register file
    assign bypass1 = exe.valid && exe.rf_we && (dec.rj != '0) && (exe.rd == dec.rj);
    assign bypass2 = exe.valid && exe.rf_we && (dec.rk != '0) && (exe.rd == dec.rk);

    assign src1     = bypass1 ? exe.data : rf_rdata1;
    assign src2_reg = bypass2 ? exe.data : rf_rdata2;
    assign src2     = dec.use_imm ? dec.imm : src2_reg;

    always_comb begin
        case (dec.alu_op)
            alu_add: begin
                alu_result = src1 + src2;
            end
            alu_sub: begin
                alu_result = src1 - src2;
            end
            alu_slt: begin
                alu_result = {{(word_width-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            alu_sltu: begin
                alu_result = {{(word_width-1){1'b0}}, src1 < src2};
            end
            alu_and: begin
                alu_result = src1 & src2;
            end
            alu_or: begin
                alu_result = src1 | src2;
            end
            alu_nor: begin
                alu_result = ~(src1 | src2);
            end
            alu_xor: begin
                alu_result = src1 ^ src2;
            end
            default: begin
                alu_result = '0;
            end
        endcase
    end

    always_comb begin
        exe_next.valid = dec.valid;
        exe_next.rf_we = dec.rf_we;
        exe_next.rd    = dec.rd;
        exe_next.data  = alu_result;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exe <= '0;
        end else begin
            exe <= exe_next;
        end
    end

endmodule

/* verilog/result_stage.sv */
`timescale 1ns/100ps

module result_stage import core_pkg::*; (
    input  logic                      clk,
    input  logic                      arst_n,
    input  exec_result_t              exe,
    input  logic [reg_addr_width-1:0] rf_raddr1,
    input  logic [reg_addr_width-1:0] rf_raddr2,
    output logic [word_width-1:0]     rf_rdata1,
    output logic [word_width-1:0]     rf_rdata2,
    output wb_trace_t                 trace
);

    // r0 has no storage
    logic [word_width-1:0] regs [1:reg_count-1];

    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (exe.valid && exe.rf_we && (exe.rd != '0)) begin
            regs[exe.rd] <= exe.data;
        end
    end

    // retirement report, same edge as the write
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            trace <= '0;
        end else begin
            trace.valid <= exe.valid;
            trace.rf_we <= exe.rf_we;
            trace.rd    <= exe.rd;
            trace.data  <= exe.data;
        end
    end

endmodule

/* verilog/pipe_core.sv */
`timescale 1ns/100ps

module pipe_core import core_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       inst_valid,
    input  inst_word_u inst,
    output wb_trace_t  trace
);

    decoded_t                  dec;
    exec_result_t              exe;
    logic [reg_addr_width-1:0] rf_raddr1;
    logic [reg_addr_width-1:0] rf_raddr2;
    logic [word_width-1:0]     rf_rdata1;
    logic [word_width-1:0]     rf_rdata2;

    decode_stage u_decode (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec        (dec)
    );

    execute_stage u_execute (
        .clk       (clk),
        .arst_n    (arst_n),
        .dec       (dec),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .exe       (exe)
    );

    // register file reads answer execute in the same cycle
    result_stage u_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .exe       (exe),
        .rf_raddr1 (rf_raddr1),
        .rf_raddr2 (rf_raddr2),
        .rf_rdata1 (rf_rdata1),
        .rf_rdata2 (rf_rdata2),
        .trace     (trace)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock #(
    parameter int reset_cycles = 10
) (
    output logic clk,
    output logic arst_n
);

    localparam int half_period = 10;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

/* testbench/tb_pipe_core.sv */
`timescale 1ns/100ps

module tb_pipe_core import core_pkg::*; ();

    localparam int reset_cycles   = 10;
    localparam int case_count     = 25;
    localparam int field_count    = 5;
    localparam int pass_count     = 2;
    localparam int trace_latency  = 3;
    localparam int timeout_cycles = pass_count * case_count * 4 + reset_cycles + 20;

    typedef struct packed {
        wb_trace_t result;
        int        issue_cycle;
    } pending_t;

    logic                  clk;
    logic                  arst_n;
    logic                  inst_valid;
    inst_word_u            inst;
    wb_trace_t             trace;
    logic [word_width-1:0] case_mem [case_count*field_count];
    pending_t              expect_q [$];
    int                    cycle = 0;

    tb_clock #(
        .reset_cycles (reset_cycles)
    ) i_clock (
        .clk    (clk),
        .arst_n (arst_n)
    );

    pipe_core i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .trace      (trace)
    );

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1);
    endtask

    // galois form, taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    task automatic compare_data(input string name, input logic [word_width-1:0] got,
                                input logic [word_width-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic compare_trace(input wb_trace_t got, input wb_trace_t exp);
        if (got.rf_we !== exp.rf_we) begin
            $display("Error at %0t: trace.rf_we is %0b, expected %0b", $time, got.rf_we,
                     exp.rf_we);
            stop_with_failure();
        end
        if (got.rd !== exp.rd) begin
            $display("Error at %0t: trace.rd is %0d, expected %0d", $time, got.rd, exp.rd);
            stop_with_failure();
        end
        compare_data("trace.data", got.data, exp.data);
    endtask

    task automatic compare_latency(input int got);
        if (got != trace_latency) begin
            $display("Error at %0t: trace.valid latency is %0d cycles, expected %0d", $time,
                     got, trace_latency);
            stop_with_failure();
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= timeout_cycles) begin
            $display("Timeout after %0d cycles, %0d retirements still outstanding", cycle,
                     expect_q.size());
            stop_with_failure();
        end
    end

    // trace is stable on the falling edge
    always @(negedge clk) begin
        pending_t head;
        if (trace.valid) begin
            if (expect_q.size() == 0) begin
                $display("trace.valid strobed for rd %0d with no retiring instruction issued",
                         trace.rd);
                stop_with_failure();
            end else begin
                head = expect_q.pop_front();
                compare_latency(cycle - head.issue_cycle);
                compare_trace(trace, head.result);
            end
        end
    end

    initial begin
        logic [1:0]  gap;
        logic [31:0] lfsr_state;
        int          base;
        int          last_issue;
        pending_t    item;

        $timeformat(-9, 1, " ns", 10);
        inst_valid <= 1'b0;
        inst       <= '0;
        lfsr_state = 32'he2dd_f4c1;
        last_issue = 0;
        // entries the file leaves alone keep their address in the low bits
        for (int i = 0; i < case_count * field_count; i++) begin
            case_mem[i] = 32'hbad0_0000 | i;
        end
        $readmemh("testbench/pipe_cases.txt", case_mem);
        for (int i = 0; i < case_count * field_count; i++) begin
            if ($isunknown(case_mem[i]) || case_mem[i] == (32'hbad0_0000 | i)) begin
                $display("Case file is missing or holds fewer than %0d cases", case_count);
                stop_with_failure();
            end
        end

        wait (arst_n === 1'b1);
        for (int pass = 0; pass < pass_count; pass++) begin
            for (int i = 0; i < case_count; i++) begin
                base = i * field_count;
                @(posedge clk);
                inst_valid <= 1'b1;
                inst       <= inst_word_u'(case_mem[base]);
                last_issue = cycle;
                if (case_mem[base+1][0]) begin
                    item.result.valid = 1'b1;
                    item.result.rf_we = case_mem[base+2][0];
                    item.result.rd    = case_mem[base+3][reg_addr_width-1:0];
                    item.result.data  = case_mem[base+4];
                    // counter steps at this same edge
                    item.issue_cycle  = cycle + 1;
                    expect_q.push_back(item);
                end
                // first pass runs back to back so every neighbour takes the bypass
                gap = 2'd0;
                if (pass != 0) begin
                    repeat (2) begin
                        gap        = {gap[0], lfsr_state[0]};
                        lfsr_state = lfsr_next(lfsr_state);
                    end
                end
                repeat (gap) begin
                    @(posedge clk);
                    inst_valid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        inst_valid <= 1'b0;

        while (cycle < last_issue + trace_latency + 1) begin
            @(posedge clk);
        end
        if (expect_q.size() != 0) begin
            $display("%0d retirements missing after the last instruction", expect_q.size());
            stop_with_failure();
        end else begin
            // quiet window for stray strobes
            repeat (4) @(posedge clk);
            $display("Test OK");
            $finish;
        end
    end

endmodule

/* build.f */
verilog/core_pkg.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/result_stage.sv
verilog/pipe_core.sv
testbench/tb_clock.sv
testbench/tb_pipe_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_pipe_core
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/pipe_cases.txt */
// instruction word, retires (1) or dropped (0), rf_we, rd, write-back data
// registers start at zero and every source is written earlier in the list
02801401 1 1 01 00000005 // addi  r1, r0, 5
02bff402 1 1 02 fffffffd // addi  r2, r0, -3
029ffc23 1 1 03 00000804 // addi  r3, r1, 0x7ff
00100864 1 1 04 00000801 // add   r4, r3, r2
00110445 1 1 05 fffffff8 // sub   r5, r2, r1
00120446 1 1 06 00000001 // slt   r6, r2, r1
00128447 1 1 07 00000000 // sltu  r7, r2, r1
00140828 1 1 08 00000002 // nor   r8, r1, r2
00148c89 1 1 09 00000800 // and   r9, r4, r3
0015102a 1 1 0a 00000805 // or    r10, r1, r4
00158d4b 1 1 0b 00000001 // xor   r11, r10, r3
00000000 0 0 00 00000000 // illegal, all zero
023ff84c 1 1 0c 00000001 // slti  r12, r2, -2
027ffc2d 1 1 0d 00000001 // sltui r13, r1, -1
0240104e 1 1 0e 00000000 // sltui r14, r2, 4
037c3c4f 1 1 0f 00000f0d // andi  r15, r2, 0xf0f
03a00030 1 1 10 00000805 // ori   r16, r1, 0x800
03fffe11 1 1 11 000007fa // xori  r17, r16, 0xfff
ffffffff 0 0 00 00000000 // illegal, all ones
02848c20 1 0 00 00000128 // addi  r0, r1, 0x123
00100412 1 1 12 00000005 // add   r18, r0, r1
00108443 0 0 00 00000000 // illegal 3R opcode 0x21
00110233 1 1 13 000007fa // sub   r19, r17, r0
00128814 1 1 14 00000001 // sltu  r20, r0, r2
001208b5 1 1 15 00000001 // slt   r21, r5, r2
